// File: Makefile
# Verilator build and run for the 720p video output stage

VERILATOR ?= verilator
TOP       ?= tb_vid_out
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then \
	  echo "simulation failed"; exit 1; \
	fi
	@grep -q "Finished with no errors" $(LOG) || { echo "simulation incomplete"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: data_controller.sv
`timescale 1ns/100ps

module data_controller (
  input  logic               i_clk_74M,
  input  logic               i_rst,
  input  vid_pkg::cnt_t      i_hcnt,
  input  vid_pkg::cnt_t      i_vcnt,
  input  vid_pkg::out_mode_e i_mode,
  input  vid_pkg::pix_word_t i_rd_data,
  input  logic               i_empty,
  output logic               o_fifo_rd,
  output logic               o_de,
  output vid_pkg::chan_t     o_r,
  output vid_pkg::chan_t     o_g,
  output vid_pkg::chan_t     o_b
);
  import vid_pkg::*;

  localparam cnt_t LAST_COL = cnt_t'(H_FIN - H_START - 1);

  logic        hactive;
  logic        vactive;
  cnt_t        col;
  cnt_t        line;
  logic        half;
  pix_word_t   word;
  // stage B registers
  logic        de_q;
  logic        blank_q;
  out_mode_e   mode_q;
  chan_t       y_q;
  chan_t       cb_q;
  chan_t       cr_q;
  chan_t       pat_b_q;
  chan_t       pat_g_q;
  // conversion sums, 19 bit unsigned wraparound
  logic [18:0] r_sum;
  logic [18:0] g_sum;
  logic [18:0] b_sum;

  // one pop per active pixel
  assign o_fifo_rd = hactive & vactive;
  // starved pop behaves as an all-zero word
  assign word      = i_empty ? '0 : i_rd_data;
  assign half      = (col >= cnt_t'(BLOCK_SPLIT));

  // --------------------------------------------------
  // stage A: active window, column and line indices
  // --------------------------------------------------
  always_ff @(posedge i_clk_74M) begin
    if (i_rst) begin
      hactive <= 1'b0;
      vactive <= 1'b0;
      col     <= '0;
      line    <= '0;
    end else begin
      if (i_hcnt == cnt_t'(H_START)) hactive <= 1'b1;
      if (i_hcnt == cnt_t'(H_FIN))   hactive <= 1'b0;
      if (i_vcnt == cnt_t'(V_START)) vactive <= 1'b1;
      if (i_vcnt == cnt_t'(V_FIN))   vactive <= 1'b0;
      // column restarts in every horizontal blank
      col <= o_fifo_rd ? col + 1'b1 : '0;
      // line index steps after the last pixel of a line
      if (!vactive) begin
        line <= '0;
      end else if (o_fifo_rd && (col == LAST_COL)) begin
        line <= line + 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // stage B: capture word fields with the pop
  // --------------------------------------------------
  always_ff @(posedge i_clk_74M) begin
    if (i_rst) begin
      de_q <= 1'b0;
      cb_q <= '0;
      cr_q <= '0;
    end else begin
      de_q <= o_fifo_rd;
      // even columns carry Cb, odd columns carry Cr
      if (o_fifo_rd && !col[0]) cb_q <= word[7:0];
      if (o_fifo_rd && col[0])  cr_q <= word[7:0];
    end
  end

  always_ff @(posedge i_clk_74M) begin
    if (o_fifo_rd) begin
      y_q     <= word[15:8];
      // black on starvation or on a tag from the other half
      blank_q <= i_empty | (word[27] != half);
      mode_q  <= i_mode;
      pat_b_q <= col[9:2];
      pat_g_q <= line[8:1];
    end
  end

  // fixed-point YCbCr to RGB, low byte of sum >> 8 kept
  assign r_sum = {3'b0, y_q, 8'h00} + 19'd359 * {11'b0, cr_q} - 19'h0B380;
  assign g_sum = {3'b0, y_q, 8'h00} + 19'h08780 - 19'd183 * {11'b0, cr_q}
                 - 19'd88 * {11'b0, cb_q};
  assign b_sum = {3'b0, y_q, 8'h00} + 19'd454 * {11'b0, cb_q} - 19'h0E300;

  // --------------------------------------------------
  // stage C: registered outputs
  // --------------------------------------------------
  always_ff @(posedge i_clk_74M) begin
    if (i_rst) begin
      o_de <= 1'b0;
      o_r  <= '0;
      o_g  <= '0;
      o_b  <= '0;
    end else begin
      o_de <= de_q;
      if (!de_q || ((mode_q == MODE_VIDEO) && blank_q)) begin
        o_r <= '0;
        o_g <= '0;
        o_b <= '0;
      end else if (mode_q == MODE_PATTERN) begin
        o_r <= '0;
        o_g <= pat_g_q;
        o_b <= pat_b_q;
      end else begin
        o_r <= r_sum[15:8];
        o_g <= g_sum[15:8];
        o_b <= b_sum[15:8];
      end
    end
  end

  // pops only land on active counter positions of the timing generator
  a_rd_in_window : assert property (@(posedge i_clk_74M) disable iff (i_rst)
    o_fifo_rd |-> (i_vcnt >= cnt_t'(V_START)) && (i_vcnt < cnt_t'(V_FIN)) &&
                  (i_hcnt > cnt_t'(H_START)) && (i_hcnt <= cnt_t'(H_FIN)))
    else $error("FIFO pop outside active window");

endmodule

// File: pix_fifo.sv
`timescale 1ns/100ps

module pix_fifo (
  input  logic               i_clk_74M,
  input  logic               i_rst,
  input  logic               i_wr,
  input  vid_pkg::pix_word_t i_wr_data,
  input  logic               i_rd,
  output vid_pkg::pix_word_t o_rd_data,
  output logic               o_empty,
  output logic               o_full,
  output vid_pkg::lvl_t      o_level,
  output logic               o_underflow
);
  import vid_pkg::*;

  pix_word_t          mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic               do_wr;
  logic               do_rd;

  assign o_empty = (o_level == '0);
  assign o_full  = (o_level == lvl_t'(FIFO_DEPTH));
  // writes while full are dropped
  assign do_wr   = i_wr & ~o_full;
  assign do_rd   = i_rd & ~o_empty;

  // head word shows without a read cycle
  assign o_rd_data = mem[rd_ptr];

  // storage
  always_ff @(posedge i_clk_74M) begin
    if (do_wr) begin
      mem[wr_ptr] <= i_wr_data;
    end
  end

  // --------------------------------------------------
  // pointers, level and underflow pulse
  // --------------------------------------------------
  always_ff @(posedge i_clk_74M) begin
    if (i_rst) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      o_level     <= '0;
      o_underflow <= 1'b0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // read plus write leaves the level alone
      case ({do_wr, do_rd})
        2'b10:   o_level <= o_level + 1'b1;
        2'b01:   o_level <= o_level - 1'b1;
        default: o_level <= o_level;
      endcase
      // one-cycle pulse after a pop of an empty FIFO
      o_underflow <= i_rd & o_empty;
    end
  end

  a_no_wr_full : assert property (@(posedge i_clk_74M) disable iff (i_rst)
    !(i_wr && o_full))
    else $error("pixel write while FIFO full");

endmodule

// File: sources.f
vid_pkg.sv
vid_timing_gen.sv
pix_fifo.sv
data_controller.sv
vid_apb_regs.sv
vid_out_top.sv
tb_vid_checker.sv
tb_vid_out.sv

// File: tb_vid_checker.sv
`timescale 1ns/100ps

module tb_vid_checker (
  input  logic               i_clk_74M,
  input  logic               i_rst,
  // pixel write port as seen at the DUT boundary
  input  logic               i_pix_wr,
  input  vid_pkg::pix_word_t i_pix_data,
  input  logic               i_pix_full,
  // APB bus
  input  logic               i_psel,
  input  logic               i_penable,
  input  logic               i_pwrite,
  input  vid_pkg::apb_addr_t i_paddr,
  input  vid_pkg::apb_data_t i_pwdata,
  input  vid_pkg::apb_data_t i_prdata,
  input  logic               i_pready,
  input  logic               i_pslverr,
  // video output
  input  logic               i_hsync_n,
  input  logic               i_vsync_n,
  input  logic               i_de,
  input  vid_pkg::chan_t     i_r,
  input  vid_pkg::chan_t     i_g,
  input  vid_pkg::chan_t     i_b,
  output int                 o_errors,
  output int                 o_pixels,
  output int                 o_starved,
  output int                 o_frames
);
  import vid_pkg::*;

  // model of the FIFO contents, in write order
  pix_word_t words [$];
  int        col;
  int        line;
  // accepted writes one and two clocks back, not yet visible at the pop
  int        wr_d1;
  int        wr_d2;
  // sync pulse lengths and clocks since the last hsync fall
  int        hs_low;
  int        hs_gap;
  int        vs_low;
  chan_t     cb;
  chan_t     cr;
  logic      uf;
  out_mode_e mode;

  task automatic report_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    $display("Error %s: expected 0x%0h, actual 0x%0h at %0t", name, exp, act, $time);
    o_errors++;
  endtask

  // ycbcr to rgb, low byte of the fixed-point sum >> 8
  function automatic chan_t conv_r(input chan_t y, input chan_t v);
    int s;
    s = 256 * int'(y) + 359 * int'(v) - 'hB380;
    return s[15:8];
  endfunction

  function automatic chan_t conv_g(input chan_t y, input chan_t u, input chan_t v);
    int s;
    s = 256 * int'(y) + 'h8780 - 183 * int'(v) - 88 * int'(u);
    return s[15:8];
  endfunction

  function automatic chan_t conv_b(input chan_t y, input chan_t u);
    int s;
    s = 256 * int'(y) + 454 * int'(u) - 'hE300;
    return s[15:8];
  endfunction

  // --------------------------------------------------
  // one output pixel against the model
  // --------------------------------------------------
  task automatic check_pixel();
    pix_word_t   w;
    logic        starve;
    logic        half;
    logic [23:0] exp;
    logic [23:0] act;
    string       name;
    // words written in the last two clocks were not there at the pop
    if (words.size() - wr_d1 - wr_d2 > 0) begin
      w      = words.pop_front();
      starve = 1'b0;
    end else begin
      w      = '0;
      starve = 1'b1;
      uf     = 1'b1;
      o_starved++;
    end
    // even columns carry cb, odd columns cr
    if (col[0] == 1'b0) begin
      cb = w[7:0];
    end else begin
      cr = w[7:0];
    end
    half = (col >= BLOCK_SPLIT);
    if (mode == MODE_PATTERN) begin
      name = "pattern";
      exp  = {8'h00, line[8:1], col[9:2]};
    end else if (starve) begin
      name = "starve";
      exp  = '0;
    end else if (w[27] != half) begin
      name = "gating";
      exp  = '0;
    end else begin
      name = "convert";
      exp  = {conv_r(w[15:8], cr), conv_g(w[15:8], cb, cr), conv_b(w[15:8], cb)};
    end
    act = {i_r, i_g, i_b};
    if (act !== exp) begin
      report_value(name, 32'(exp), 32'(act));
    end
    o_pixels++;
  endtask

  // expected register contents at the access phase
  task automatic check_read();
    apb_data_t exp;
    exp = '0;
    if (i_paddr == REG_CTRL) begin
      exp[0] = (mode == MODE_VIDEO);
      if (i_prdata !== exp) report_value("apb_ctrl", exp, i_prdata);
    end else if (i_paddr == REG_STATUS) begin
      exp[14:8] = lvl_t'(words.size());
      exp[0]    = uf;
      if (i_prdata !== exp) report_value("apb_status", exp, i_prdata);
    end
  endtask

  always @(posedge i_clk_74M) begin
    if (i_rst) begin
      words.delete();
      col       = 0;
      line      = 0;
      wr_d1     = 0;
      wr_d2     = 0;
      hs_low    = 0;
      hs_gap    = -1;
      vs_low    = 0;
      cb        = '0;
      cr        = '0;
      uf        = 1'b0;
      mode      = MODE_PATTERN;
      o_errors  = 0;
      o_pixels  = 0;
      o_starved = 0;
      o_frames  = 0;
    end else begin
      if (i_de) begin
        check_pixel();
        col++;
      end else if (col != 0) begin
        // falling edge of de closes a line
        if (col != H_FIN - H_START) report_value("line_length", H_FIN - H_START, col);
        line++;
        col = 0;
      end
      // vertical sync closes a frame
      if (!i_vsync_n) begin
        if (line != 0) begin
          if (line != V_FIN - V_START) report_value("frame_lines", V_FIN - V_START, line);
          o_frames++;
        end
        line = 0;
      end
      // --------------------------------------------------
      // sync pulse widths and line period
      // --------------------------------------------------
      if (!i_hsync_n) begin
        // hsync fall starts a new line period
        if (hs_low == 0) begin
          if ((hs_gap >= 0) && (hs_gap != H_TOTAL)) begin
            report_value("hsync_period", H_TOTAL, hs_gap);
          end
          hs_gap = 0;
        end
        hs_low++;
      end else if (hs_low != 0) begin
        if (hs_low != H_SYNC_END) report_value("hsync_width", H_SYNC_END, hs_low);
        hs_low = 0;
      end
      if (hs_gap >= 0) hs_gap++;
      if (!i_vsync_n) begin
        vs_low++;
      end else if (vs_low != 0) begin
        // vertical pulse spans whole lines
        if (vs_low != V_SYNC_END * H_TOTAL) begin
          report_value("vsync_width", V_SYNC_END * H_TOTAL, vs_low);
        end
        vs_low = 0;
      end
      // --------------------------------------------------
      // APB access phase
      // --------------------------------------------------
      if (i_psel && i_penable) begin
        // zero wait states and no error responses
        if (i_pready !== 1'b1) report_value("apb_pready", 1, i_pready);
        if (i_pslverr !== 1'b0) report_value("apb_pslverr", 0, i_pslverr);
        if (!i_pwrite) begin
          check_read();
        end else if (i_paddr == REG_CTRL) begin
          mode = out_mode_e'(i_pwdata[0]);
        end else if ((i_paddr == REG_STATUS) && i_pwdata[0]) begin
          uf = 1'b0;
        end
      end
      // writes land after this edge's pop bookkeeping
      wr_d2 = wr_d1;
      wr_d1 = 0;
      if (i_pix_wr && !i_pix_full) begin
        words.push_back(i_pix_data);
        wr_d1 = 1;
      end
    end
  end

endmodule

// File: tb_vid_out.sv
`timescale 1ns/100ps

module tb_vid_out;
  import vid_pkg::*;

  localparam int CLK_PERIOD  = 8;
  localparam int FRAMES      = 3;
  // four full frames of pixel clocks
  localparam int WATCHDOG_NS = 4 * H_TOTAL * V_TOTAL * CLK_PERIOD;

  logic      clk_74M;
  logic      rst;
  logic      pix_wr   = 1'b0;
  pix_word_t pix_data = '0;
  logic      pix_full;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;
  logic      hsync_n;
  logic      vsync_n;
  logic      de;
  chan_t     r;
  chan_t     g;
  chan_t     b;
  // stream feeder enable, dropped for the starvation test
  logic      feed_en  = 1'b1;
  integer    seed     = 32'hca05;
  logic [31:0] rnd;
  int        errors;
  int        pixels;
  int        starved;
  int        frames;
  int        tb_errors;

  vid_out_top u_vid_out_top (
    .i_clk_74M  (clk_74M),
    .i_rst      (rst),
    .i_pix_wr   (pix_wr),
    .i_pix_data (pix_data),
    .o_pix_full (pix_full),
    .i_psel     (psel),
    .i_penable  (penable),
    .i_pwrite   (pwrite),
    .i_paddr    (paddr),
    .i_pwdata   (pwdata),
    .o_prdata   (prdata),
    .o_pready   (pready),
    .o_pslverr  (pslverr),
    .o_hsync_n  (hsync_n),
    .o_vsync_n  (vsync_n),
    .o_de       (de),
    .o_r        (r),
    .o_g        (g),
    .o_b        (b)
  );

  tb_vid_checker u_checker (
    .i_clk_74M  (clk_74M),
    .i_rst      (rst),
    .i_pix_wr   (pix_wr),
    .i_pix_data (pix_data),
    .i_pix_full (pix_full),
    .i_psel     (psel),
    .i_penable  (penable),
    .i_pwrite   (pwrite),
    .i_paddr    (paddr),
    .i_pwdata   (pwdata),
    .i_prdata   (prdata),
    .i_pready   (pready),
    .i_pslverr  (pslverr),
    .i_hsync_n  (hsync_n),
    .i_vsync_n  (vsync_n),
    .i_de       (de),
    .i_r        (r),
    .i_g        (g),
    .i_b        (b),
    .o_errors   (errors),
    .o_pixels   (pixels),
    .o_starved  (starved),
    .o_frames   (frames)
  );

  initial begin
    clk_74M = 1'b0;
    forever #(CLK_PERIOD / 2) clk_74M = ~clk_74M;
  end

  // keep the FIFO topped up to half full with random words
  always @(posedge clk_74M) begin
    if (rst || !feed_en || (u_vid_out_top.fifo_level >= lvl_t'(FIFO_DEPTH / 2))) begin
      pix_wr <= 1'b0;
    end else begin
      rnd = $random(seed);
      pix_wr   <= 1'b1;
      pix_data <= rnd[28:0];
    end
  end

  // one APB transfer, setup then access until pready
  task automatic apb_transfer(input logic write, input apb_addr_t addr,
                              input apb_data_t data);
    @(posedge clk_74M);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk_74M);
    penable <= 1'b1;
    @(posedge clk_74M);
    while (!pready) @(posedge clk_74M);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial begin
    rst       = 1'b1;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    tb_errors = 0;
    repeat (2) @(posedge clk_74M);
    rst <= 1'b0;
    // control reads back pattern mode, then one pattern frame runs
    apb_transfer(1'b0, REG_CTRL, '0);
    @(negedge vsync_n);
    // switch to video inside vertical blank
    apb_transfer(1'b1, REG_CTRL, apb_data_t'(MODE_VIDEO));
    apb_transfer(1'b0, REG_CTRL, '0);
    apb_transfer(1'b0, REG_STATUS, '0);
    @(posedge vsync_n);
    // starve the FIFO for one line part way into the frame
    repeat (100) @(posedge de);
    @(posedge clk_74M);
    feed_en <= 1'b0;
    repeat (H_TOTAL) @(posedge clk_74M);
    feed_en <= 1'b1;
    @(negedge vsync_n);
    // sticky flag set, then write one to clear
    apb_transfer(1'b0, REG_STATUS, '0);
    apb_transfer(1'b1, REG_STATUS, apb_data_t'(1));
    apb_transfer(1'b0, REG_STATUS, '0);
    @(negedge vsync_n);
    apb_transfer(1'b0, REG_STATUS, '0);
    repeat (4) @(posedge clk_74M);
    if (starved == 0) begin
      $display("starvation test produced no starved pixels");
      tb_errors++;
    end
    if (frames != FRAMES) begin
      $display("Error frame_count: expected 0x%0h, actual 0x%0h", FRAMES, frames);
      tb_errors++;
    end
    $display("errors: %0d, testbench errors: %0d, pixels checked: %0d, starved: %0d",
             errors, tb_errors, pixels, starved);
    if ((errors + tb_errors) == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired, the run did not finish within four frame times");
    $display("Finished with errors");
    $finish;
  end

endmodule

// File: vid_apb_regs.sv
`timescale 1ns/100ps

module vid_apb_regs (
  input  logic               i_clk_74M,
  input  logic               i_rst,
  input  logic               i_psel,
  input  logic               i_penable,
  input  logic               i_pwrite,
  input  vid_pkg::apb_addr_t i_paddr,
  input  vid_pkg::apb_data_t i_pwdata,
  input  logic               i_underflow,
  input  vid_pkg::lvl_t      i_level,
  output vid_pkg::apb_data_t o_prdata,
  output logic               o_pready,
  output logic               o_pslverr,
  output vid_pkg::out_mode_e o_mode
);
  import vid_pkg::*;

  logic wr_en;
  logic rd_en;
  logic clr_uf;
  logic uf_flag;

  // zero wait states and no error responses
  assign o_pready  = 1'b1;
  assign o_pslverr = 1'b0;

  // transfers complete in the access phase
  assign wr_en  = i_psel & i_penable & i_pwrite;
  assign rd_en  = i_psel & i_penable & ~i_pwrite;
  // write-one-to-clear on status bit 0
  assign clr_uf = wr_en && (i_paddr == REG_STATUS) && i_pwdata[0];

  // --------------------------------------------------
  // control mode and sticky underflow
  // --------------------------------------------------
  always_ff @(posedge i_clk_74M) begin
    if (i_rst) begin
      o_mode  <= MODE_PATTERN;
      uf_flag <= 1'b0;
    end else begin
      if (wr_en && (i_paddr == REG_CTRL)) begin
        o_mode <= out_mode_e'(i_pwdata[0]);
      end
      // fresh underflow beats a clear in the same cycle
      if (i_underflow) begin
        uf_flag <= 1'b1;
      end else if (clr_uf) begin
        uf_flag <= 1'b0;
      end
    end
  end

  // read mux
  always_comb begin
    o_prdata = '0;
    if (rd_en) begin
      case (i_paddr)
        REG_CTRL: begin
          o_prdata[0] = (o_mode == MODE_VIDEO);
        end
        REG_STATUS: begin
          o_prdata[14:8] = i_level;
          o_prdata[0]    = uf_flag;
        end
        default: begin
          o_prdata = '0;
        end
      endcase
    end
  end

  // every access phase is preceded by its setup phase
  a_apb_setup : assert property (@(posedge i_clk_74M) disable iff (i_rst)
    (i_psel && i_penable) |-> $past(i_psel && !i_penable))
    else $error("APB access without setup phase");

endmodule

// File: vid_out_top.sv
`timescale 1ns/100ps

module vid_out_top (
  input  logic               i_clk_74M,
  input  logic               i_rst,
  // pixel write port
  input  logic               i_pix_wr,
  input  vid_pkg::pix_word_t i_pix_data,
  output logic               o_pix_full,
  // APB register port
  input  logic               i_psel,
  input  logic               i_penable,
  input  logic               i_pwrite,
  input  vid_pkg::apb_addr_t i_paddr,
  input  vid_pkg::apb_data_t i_pwdata,
  output vid_pkg::apb_data_t o_prdata,
  output logic               o_pready,
  output logic               o_pslverr,
  // video out
  output logic               o_hsync_n,
  output logic               o_vsync_n,
  output logic               o_de,
  output vid_pkg::chan_t     o_r,
  output vid_pkg::chan_t     o_g,
  output vid_pkg::chan_t     o_b
);
  import vid_pkg::*;

  cnt_t      hcnt;
  cnt_t      vcnt;
  pix_word_t fifo_data;
  logic      fifo_rd;
  logic      fifo_empty;
  logic      fifo_underflow;
  lvl_t      fifo_level;
  out_mode_e mode;

  // --------------------------------------------------
  // timing, buffering, pixel path, registers
  // --------------------------------------------------
  vid_timing_gen u_timing (
    .i_clk_74M (i_clk_74M),
    .i_rst     (i_rst),
    .o_hcnt    (hcnt),
    .o_vcnt    (vcnt),
    .o_hsync_n (o_hsync_n),
    .o_vsync_n (o_vsync_n)
  );

  pix_fifo u_fifo (
    .i_clk_74M   (i_clk_74M),
    .i_rst       (i_rst),
    .i_wr        (i_pix_wr),
    .i_wr_data   (i_pix_data),
    .i_rd        (fifo_rd),
    .o_rd_data   (fifo_data),
    .o_empty     (fifo_empty),
    .o_full      (o_pix_full),
    .o_level     (fifo_level),
    .o_underflow (fifo_underflow)
  );

  data_controller u_ctrl (
    .i_clk_74M (i_clk_74M),
    .i_rst     (i_rst),
    .i_hcnt    (hcnt),
    .i_vcnt    (vcnt),
    .i_mode    (mode),
    .i_rd_data (fifo_data),
    .i_empty   (fifo_empty),
    .o_fifo_rd (fifo_rd),
    .o_de      (o_de),
    .o_r       (o_r),
    .o_g       (o_g),
    .o_b       (o_b)
  );

  vid_apb_regs u_regs (
    .i_clk_74M   (i_clk_74M),
    .i_rst       (i_rst),
    .i_psel      (i_psel),
    .i_penable   (i_penable),
    .i_pwrite    (i_pwrite),
    .i_paddr     (i_paddr),
    .i_pwdata    (i_pwdata),
    .i_underflow (fifo_underflow),
    .i_level     (fifo_level),
    .o_prdata    (o_prdata),
    .o_pready    (o_pready),
    .o_pslverr   (o_pslverr),
    .o_mode      (mode)
  );

endmodule

// File: vid_pkg.sv
package vid_pkg;

  // --------------------------------------------------
  // 720p60 frame timing in pixel clocks and lines
  // --------------------------------------------------
  localparam int H_TOTAL     = 1650;
  localparam int V_TOTAL     = 750;
  // first and last-plus-one active counter values
  localparam int H_START     = 1;
  localparam int H_FIN       = 1281;
  localparam int V_START     = 24;
  localparam int V_FIN       = 744;
  // sync pulse widths
  localparam int H_SYNC_END  = 40;
  localparam int V_SYNC_END  = 5;
  // first column of the right half of the line
  localparam int BLOCK_SPLIT = 640;

  // --------------------------------------------------
  // pixel FIFO geometry
  // --------------------------------------------------
  localparam int FIFO_DEPTH  = 64;
  localparam int FIFO_AW     = 6;

  // --------------------------------------------------
  // types
  // --------------------------------------------------
  // timing counter value
  typedef logic [11:0] cnt_t;
  // packed 4:2:2 word
  // [28:27] block tag, [26:16] line tag, [15:8] luma, [7:0] chroma
  typedef logic [28:0] pix_word_t;
  typedef logic [7:0]  chan_t;
  // FIFO fill level, 0 up to FIFO_DEPTH inclusive
  typedef logic [6:0]  lvl_t;
  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // control bit 0 picks the output source
  typedef enum logic {
    MODE_PATTERN = 1'b0,
    MODE_VIDEO   = 1'b1
  } out_mode_e;

  // register map
  localparam apb_addr_t REG_CTRL   = 8'h00;
  localparam apb_addr_t REG_STATUS = 8'h04;

endpackage

// File: vid_timing_gen.sv
`timescale 1ns/100ps

module vid_timing_gen (
  input  logic          i_clk_74M,
  input  logic          i_rst,
  output vid_pkg::cnt_t o_hcnt,
  output vid_pkg::cnt_t o_vcnt,
  output logic          o_hsync_n,
  output logic          o_vsync_n
);
  import vid_pkg::*;

  logic line_end;
  logic frame_end;

  // last pixel of a line and last line of a frame
  assign line_end  = (o_hcnt == cnt_t'(H_TOTAL - 1));
  assign frame_end = (o_vcnt == cnt_t'(V_TOTAL - 1));

  // --------------------------------------------------
  // pixel and line counters
  // --------------------------------------------------
  always_ff @(posedge i_clk_74M) begin
    if (i_rst) begin
      o_hcnt <= '0;
      o_vcnt <= '0;
    end else if (line_end) begin
      o_hcnt <= '0;
      // line counter steps once per wrapped line
      if (frame_end) begin
        o_vcnt <= '0;
      end else begin
        o_vcnt <= o_vcnt + 1'b1;
      end
    end else begin
      o_hcnt <= o_hcnt + 1'b1;
    end
  end

  // --------------------------------------------------
  // syncs, active low, placed at the end of blanking
  // --------------------------------------------------
  always_ff @(posedge i_clk_74M) begin
    if (i_rst) begin
      o_hsync_n <= 1'b1;
      o_vsync_n <= 1'b1;
    end else begin
      o_hsync_n <= ~(o_hcnt >= cnt_t'(H_TOTAL - H_SYNC_END));
      o_vsync_n <= ~(o_vcnt >= cnt_t'(V_TOTAL - V_SYNC_END));
    end
  end

  // counter must wrap before reaching the line length
  a_hcnt_range : assert property (@(posedge i_clk_74M) disable iff (i_rst)
    o_hcnt < cnt_t'(H_TOTAL))
    else $error("hcnt out of range: %0d", o_hcnt);

endmodule
